// ==== common/channel_mux_pkg.sv ====
// Channel mux package.
// Sample sizes, the parallel sample word and the per-channel stream beat
// shared by the differentiator, the channel mux and the top level.

`default_nettype none

package channel_mux_pkg;

  // **************************************************************************
  // Sizes
  // **************************************************************************

  // Bits per sample and samples per beat.
  localparam int SAMPLE_WIDTH = 16;
  localparam int PARALLEL_SAMPLES = 16;

  // Raw stream plus its first difference.
  // Source s < CHANNELS is raw channel s, source CHANNELS+k is the
  // difference stream of channel k.
  localparam int SOURCES_PER_CHANNEL = 2;

  // **************************************************************************
  // Types
  // **************************************************************************

  typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

  // Element 0 is the oldest sample of the beat.
  typedef sample_t [PARALLEL_SAMPLES-1:0] sample_word_t;

  // One channel's beat, consumed in the cycle valid is high.
  typedef struct packed {
    logic         valid;
    sample_word_t data;
  } stream_beat_t;

endpackage

`default_nettype wire

// ==== rtl/sample_differentiator.sv ====
// Sample differentiator.
// Registers each channel's raw beat and, alongside it, the first difference
// of consecutive samples. One cycle of latency for both source streams.

`timescale 1ns/1ps
`default_nettype none

module sample_differentiator #(
  parameter int CHANNELS = 8
) (
  input  logic clk,
  input  logic reset,
  input  channel_mux_pkg::stream_beat_t [CHANNELS-1:0] data_in,
  output channel_mux_pkg::stream_beat_t
         [channel_mux_pkg::SOURCES_PER_CHANNEL*CHANNELS-1:0] sources
);

  import channel_mux_pkg::*;

  // Difference of each sample against its predecessor, wrapping on overflow.
  // Sample 0 is taken against the last sample of the previous valid beat.
  function automatic sample_word_t diff_word(input sample_word_t word,
                                             input sample_t last);
    sample_word_t result;
    result[0] = word[0] - last;
    for (int i = 1; i < PARALLEL_SAMPLES; i++) begin
      result[i] = word[i] - word[i-1];
    end
    return result;
  endfunction

  // Last sample of each channel's previous valid beat.
  sample_t [CHANNELS-1:0] history_q;

  // Raw and difference beats share one valid per channel.
  logic [CHANNELS-1:0] valid_q;
  sample_word_t [CHANNELS-1:0] raw_q;
  sample_word_t [CHANNELS-1:0] diff_q;

  // **************************************************************************
  // Control and history
  // **************************************************************************

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;
      history_q <= '0;
    end else begin
      for (int k = 0; k < CHANNELS; k++) begin
        valid_q[k] <= data_in[k].valid;
        // Idle cycles leave the history alone.
        if (data_in[k].valid) begin
          history_q[k] <= data_in[k].data[PARALLEL_SAMPLES-1];
        end
      end
    end
  end

  // **************************************************************************
  // Payload
  // **************************************************************************

  always_ff @(posedge clk) begin
    for (int k = 0; k < CHANNELS; k++) begin
      if (data_in[k].valid) begin
        raw_q[k] <= data_in[k].data;
        diff_q[k] <= diff_word(data_in[k].data, history_q[k]);
      end
    end
  end

  // Raw streams first, then the difference streams in channel order.
  always_comb begin
    for (int k = 0; k < CHANNELS; k++) begin
      sources[k].valid = valid_q[k];
      sources[k].data = raw_q[k];
      sources[CHANNELS+k].valid = valid_q[k];
      sources[CHANNELS+k].data = diff_q[k];
    end
  end

endmodule

`default_nettype wire

// ==== channel_mux/channel_mux.sv ====
// Channel mux.
// Each output channel picks one of the raw or difference sources through a
// select register loaded from the configuration port, and registers it.

`timescale 1ns/1ps
`default_nettype none

module channel_mux #(
  parameter int CHANNELS = 8
) (
  input  logic clk,
  input  logic reset,
  input  channel_mux_pkg::stream_beat_t
         [channel_mux_pkg::SOURCES_PER_CHANNEL*CHANNELS-1:0] sources,
  input  logic config_valid,
  input  logic
         [CHANNELS-1:0][$clog2(channel_mux_pkg::SOURCES_PER_CHANNEL*CHANNELS)-1:0]
         config_data,
  output channel_mux_pkg::stream_beat_t [CHANNELS-1:0] data_out
);

  import channel_mux_pkg::*;

  localparam int NUM_SOURCES = SOURCES_PER_CHANNEL * CHANNELS;
  localparam int SELECT_BITS = $clog2(NUM_SOURCES);

  // Select field per output channel, and the same field after clamping.
  logic [CHANNELS-1:0][SELECT_BITS-1:0] select_q;
  logic [CHANNELS-1:0][SELECT_BITS-1:0] select_idx;

  // Registered output beats.
  logic [CHANNELS-1:0] out_valid_q;
  sample_word_t [CHANNELS-1:0] out_data_q;

  // **************************************************************************
  // Select register
  // **************************************************************************

  // Zero after reset, so every output starts on raw channel 0.
  always_ff @(posedge clk) begin
    if (reset) begin
      select_q <= '0;
    end else if (config_valid) begin
      select_q <= config_data;
    end
  end

  // Spare codes exist when the source count is not a power of two.
  // They fall back to the highest source.
  always_comb begin
    for (int o = 0; o < CHANNELS; o++) begin
      if (int'(select_q[o]) >= NUM_SOURCES) begin
        select_idx[o] = SELECT_BITS'(NUM_SOURCES - 1);
      end else begin
        select_idx[o] = select_q[o];
      end
    end
  end

  // **************************************************************************
  // Source selection and output registers
  // **************************************************************************

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid_q <= '0;
    end else begin
      for (int o = 0; o < CHANNELS; o++) begin
        out_valid_q[o] <= sources[select_idx[o]].valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int o = 0; o < CHANNELS; o++) begin
      out_data_q[o] <= sources[select_idx[o]].data;
    end
  end

  always_comb begin
    for (int o = 0; o < CHANNELS; o++) begin
      data_out[o].valid = out_valid_q[o];
      data_out[o].data = out_data_q[o];
    end
  end

endmodule

`default_nettype wire

// ==== rtl/channel_mux_top.sv ====
// Channel mux top level.
// Input differentiator feeding the per-output source mux.
// Two cycles from data_in to data_out.

`timescale 1ns/1ps
`default_nettype none

module channel_mux_top #(
  parameter int CHANNELS = 8
) (
  input  logic clk,
  input  logic reset,
  input  channel_mux_pkg::stream_beat_t [CHANNELS-1:0] data_in,
  input  logic config_valid,
  input  logic
         [CHANNELS-1:0][$clog2(channel_mux_pkg::SOURCES_PER_CHANNEL*CHANNELS)-1:0]
         config_data,
  output channel_mux_pkg::stream_beat_t [CHANNELS-1:0] data_out
);

  import channel_mux_pkg::*;

  localparam int NUM_SOURCES = SOURCES_PER_CHANNEL * CHANNELS;

  // Raw streams followed by the difference streams.
  stream_beat_t [NUM_SOURCES-1:0] sources;

  // **************************************************************************
  // Input side
  // **************************************************************************

  sample_differentiator #(
    .CHANNELS (CHANNELS)
  ) differentiator_i (
    .clk     (clk),
    .reset   (reset),
    .data_in (data_in),
    .sources (sources)
  );

  // **************************************************************************
  // Processing
  // **************************************************************************

  channel_mux #(
    .CHANNELS (CHANNELS)
  ) mux_i (
    .clk          (clk),
    .reset        (reset),
    .sources      (sources),
    .config_valid (config_valid),
    .config_data  (config_data),
    .data_out     (data_out)
  );

endmodule

`default_nettype wire

// ==== verification/channel_mux_ref.svh ====
// Channel mux reference model.
// Expected difference words, and routing of each input beat into the
// expected queue of every output whose select names one of its sources.

`ifndef CHANNEL_MUX_REF_SVH
`define CHANNEL_MUX_REF_SVH

// **************************************************************************
// Difference stream
// **************************************************************************

// Each sample minus the one before it, modulo 2^SAMPLE_WIDTH.
// The sample before sample 0 is the last one of the previous valid beat.
function automatic sample_word_t ref_diff_word(input sample_word_t word,
                                               input sample_t prev_last);
  sample_word_t d;
  sample_t prev;
  prev = prev_last;
  for (int i = 0; i < PARALLEL_SAMPLES; i++) begin
    d[i] = sample_t'(word[i] - prev);
    prev = word[i];
  end
  return d;
endfunction

// **************************************************************************
// Source routing
// **************************************************************************

// Channel a source is derived from.
function automatic int source_channel(input int src);
  return src % CHANNELS;
endfunction

// Sources at CHANNELS and up carry the difference stream.
function automatic bit source_is_diff(input int src);
  return src >= CHANNELS;
endfunction

// One valid beat of channel k lands on every output selecting raw k or diff k.
function automatic void route_beat(input int k,
                                   input sample_word_t raw,
                                   input sample_word_t diff);
  int src;
  for (int o = 0; o < CHANNELS; o++) begin
    src = int'(sel_q[o]);
    if (source_channel(src) == k) begin
      if (source_is_diff(src)) begin
        exp_q[o].push_back(diff);
      end else begin
        exp_q[o].push_back(raw);
      end
    end
  end
endfunction

`endif

// ==== verification/channel_mux_tb.sv ====
// Channel mux testbench.
// Random raw and difference traffic through the top level, checked against
// a reference model per output and against the inputs delayed two cycles.

`timescale 1ns/1ps
`default_nettype none

module channel_mux_tb;

  import channel_mux_pkg::*;

  localparam int CHANNELS = 8;
  localparam int NUM_SOURCES = SOURCES_PER_CHANNEL * CHANNELS;
  localparam int SELECT_BITS = $clog2(NUM_SOURCES);
  localparam int CONFIG_CYCLES = 9;
  localparam int STIM_CYCLES = 2 + 34 + 8 * (CONFIG_CYCLES + 20)
                             + 4 * (CONFIG_CYCLES + 30) + 2 * (CONFIG_CYCLES + 40)
                             + 2 * (CONFIG_CYCLES + 20) + CONFIG_CYCLES + 20 + 8;

  logic clk;
  logic reset;
  stream_beat_t [CHANNELS-1:0] data_in;
  logic config_valid;
  logic [CHANNELS-1:0][SELECT_BITS-1:0] config_data;
  stream_beat_t [CHANNELS-1:0] data_out;

  // Select vector as the testbench last wrote it.
  logic [CHANNELS-1:0][SELECT_BITS-1:0] sel_q;
  logic [CHANNELS-1:0][SELECT_BITS-1:0] next_sel;

  // Expected beats per output, inputs seen one and two cycles back.
  sample_word_t exp_q [CHANNELS][$];
  stream_beat_t [CHANNELS-1:0] in_d1;
  stream_beat_t [CHANNELS-1:0] in_d2;
  sample_t [CHANNELS-1:0] history;

  int errors = 0;
  int checks = 0;

  `include "channel_mux_ref.svh"

  channel_mux_top #(
    .CHANNELS (CHANNELS)
  ) dut_i (
    .clk          (clk),
    .reset        (reset),
    .data_in      (data_in),
    .config_valid (config_valid),
    .config_data  (config_data),
    .data_out     (data_out)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // **************************************************************************
  // Checking
  // **************************************************************************

  task automatic check_value(input logic [255:0] actual, input logic [255:0] expected,
                             input string what);
    checks++;
    if (actual !== expected) begin
      $display("ERROR at %0d ns: %s: got %h, expected %h", $time, what, actual, expected);
      errors++;
    end
  endtask

  task automatic compare_outputs();
    int src;
    sample_word_t expected;
    for (int o = 0; o < CHANNELS; o++) begin
      src = int'(sel_q[o]);
      check_value(data_out[o].valid, in_d2[source_channel(src)].valid,
                  $sformatf("output %0d valid", o));
      if (data_out[o].valid === 1'b1) begin
        // Raw selects must equal the input two cycles back.
        if (!source_is_diff(src)) begin
          check_value(data_out[o].data, in_d2[src].data,
                      $sformatf("output %0d against delayed input", o));
        end
        if (exp_q[o].size() == 0) begin
          $display("Output %0d gave a beat at %0d ns with nothing expected", o, $time);
          errors++;
        end else begin
          expected = exp_q[o].pop_front();
          check_value(data_out[o].data, expected, $sformatf("output %0d data", o));
        end
      end
    end
  endtask

  task automatic record_inputs();
    sample_word_t diff;
    for (int k = 0; k < CHANNELS; k++) begin
      if (data_in[k].valid) begin
        diff = ref_diff_word(data_in[k].data, history[k]);
        history[k] = data_in[k].data[PARALLEL_SAMPLES-1];
        route_beat(k, data_in[k].data, diff);
      end
    end
  endtask

  // Inputs and outputs are both settled at the falling edge.
  always @(negedge clk) begin
    if (reset) begin
      in_d1 = '0;
      in_d2 = '0;
      history = '0;
    end else begin
      compare_outputs();
      in_d2 = in_d1;
      in_d1 = data_in;
      record_inputs();
    end
  end

  // **************************************************************************
  // Stimulus
  // **************************************************************************

  function automatic sample_word_t random_word();
    logic [255:0] w;
    for (int j = 0; j < 8; j++) begin
      w[32*j +: 32] = $urandom();
    end
    return sample_word_t'(w);
  endfunction

  // Full scale samples, so differences between them often wrap.
  function automatic sample_word_t edge_word();
    sample_word_t w;
    for (int i = 0; i < PARALLEL_SAMPLES; i++) begin
      w[i] = ($urandom_range(1) == 1) ? 16'sh7fff : 16'sh8000;
    end
    return w;
  endfunction

  task automatic drive_idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      data_in <= '0;
      config_valid <= 1'b0;
    end
  endtask

  task automatic drive_beats(input int cycles, input int valid_pct, input bit overflow);
    stream_beat_t [CHANNELS-1:0] next_in;
    repeat (cycles) begin
      for (int k = 0; k < CHANNELS; k++) begin
        next_in[k].valid = ($urandom_range(99) < valid_pct);
        next_in[k].data = overflow ? edge_word() : random_word();
      end
      @(posedge clk);
      data_in <= next_in;
    end
  endtask

  // Inputs stay idle for 4 cycles on both sides of a select change.
  task automatic write_config(input logic [CHANNELS-1:0][SELECT_BITS-1:0] new_sel);
    drive_idle(4);
    @(posedge clk);
    config_valid <= 1'b1;
    config_data <= new_sel;
    sel_q = new_sel;
    drive_idle(4);
  endtask

  task automatic random_select(input int low, input int high);
    for (int o = 0; o < CHANNELS; o++) begin
      next_sel[o] = SELECT_BITS'($urandom_range(high, low));
    end
  endtask

  initial begin
    void'($urandom(32'hd31cfca2));
    reset = 1'b1;
    data_in = '0;
    config_valid = 1'b0;
    config_data = '0;
    sel_q = '0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    // Default selects, all outputs on raw channel 0.
    drive_idle(4);
    drive_beats(30, 50, 1'b0);

    // Any source.
    repeat (8) begin
      random_select(0, NUM_SOURCES - 1);
      write_config(next_sel);
      drive_beats(20, 60, 1'b0);
    end

    // Difference sources, random and full scale data.
    repeat (4) begin
      random_select(CHANNELS, NUM_SOURCES - 1);
      write_config(next_sel);
      drive_beats(20, 60, 1'b0);
      drive_beats(10, 60, 1'b1);
    end

    // Sparse valids.
    repeat (2) begin
      random_select(0, NUM_SOURCES - 1);
      write_config(next_sel);
      drive_beats(40, 15, 1'b0);
    end

    // Shared source on most outputs.
    repeat (2) begin
      random_select(0, NUM_SOURCES - 1);
      for (int o = 0; o < CHANNELS - 2; o++) begin
        next_sel[o] = SELECT_BITS'(($urandom_range(1) == 1) ? CHANNELS + 3 : 5);
      end
      write_config(next_sel);
      drive_beats(20, 70, 1'b0);
    end

    // Each output on its own raw channel with every beat valid.
    for (int o = 0; o < CHANNELS; o++) begin
      next_sel[o] = SELECT_BITS'(o);
    end
    write_config(next_sel);
    drive_beats(20, 100, 1'b0);
    drive_idle(8);

    for (int o = 0; o < CHANNELS; o++) begin
      if (exp_q[o].size() != 0) begin
        $display("Output %0d still has %0d expected beats that never came out",
                 o, exp_q[o].size());
        errors++;
      end
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Stimulus length plus some margin.
  initial begin
    #(STIM_CYCLES * 20 + 2000);
    $display("Timeout: the run did not finish within %0d cycles", STIM_CYCLES + 100);
    $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+verification
common/channel_mux_pkg.sv
rtl/sample_differentiator.sv
channel_mux/channel_mux.sv
rtl/channel_mux_top.sv
verification/channel_mux_tb.sv
